//--- clint_axi_ctrl.sv
// CLINT AXI slave control
module clint_axi_ctrl
  import clint_pkg::*;
#(
  parameter int unsigned ID_WIDTH  = 4,
  parameter clint_addr_t BASE_ADDR = 32'h0200_0000
) (
  input  logic                clk_i,
  input  logic                rst_i,
  // write address
  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  input  clint_addr_t         aw_addr_i,
  input  logic [ID_WIDTH-1:0] aw_id_i,
  // write data
  input  logic                w_valid_i,
  output logic                w_ready_o,
  input  clint_word_t         w_data_i,
  input  clint_strb_t         w_strb_i,
  input  logic                w_last_i,
  // write response
  output logic                b_valid_o,
  input  logic                b_ready_i,
  output clint_resp_t         b_resp_o,
  output logic [ID_WIDTH-1:0] b_id_o,
  // read address
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  input  clint_addr_t         ar_addr_i,
  input  logic [ID_WIDTH-1:0] ar_id_i,
  // read data
  output logic                r_valid_o,
  input  logic                r_ready_i,
  output clint_word_t         r_data_o,
  output clint_resp_t         r_resp_o,
  output logic                r_last_o,
  output logic [ID_WIDTH-1:0] r_id_o,
  // datapath
  output logic                wr_en_o,
  output clint_sel_e          wr_sel_o,
  output clint_word_t         wr_data_o,
  output clint_strb_t         wr_strb_o,
  output clint_sel_e          rd_sel_o,
  input  clint_word_t         rd_data_i
);

  typedef enum logic {
    R_IDLE,
    R_DATA
  } r_state_e;

  typedef enum logic [1:0] {
    W_IDLE,
    W_DATA,
    W_RESP
  } w_state_e;

  r_state_e            r_state_q;
  w_state_e            w_state_q;
  logic                ar_hs;
  logic                r_hs;
  logic                aw_hs;
  logic                w_hs;
  logic                b_hs;
  clint_sel_e          aw_sel;
  clint_sel_e          wr_sel_q;
  clint_word_t         r_data_q;
  clint_resp_t         r_resp_q;
  clint_resp_t         b_resp_q;
  logic [ID_WIDTH-1:0] r_id_q;
  logic [ID_WIDTH-1:0] b_id_q;

  // exact match only, anything else is unmapped
  function automatic clint_sel_e decode(input clint_addr_t addr);
    clint_sel_e sel;
    sel = SEL_NONE;
    if (addr == BASE_ADDR + OFF_MSIP) begin
      sel = SEL_MSIP;
    end else if (addr == BASE_ADDR + OFF_MTIMECMP) begin
      sel = SEL_MTIMECMP;
    end else if (addr == BASE_ADDR + OFF_MTIME) begin
      sel = SEL_MTIME;
    end
    return sel;
  endfunction

  assign ar_hs = ar_valid_i && ar_ready_o;
  assign r_hs  = r_valid_o && r_ready_i;
  assign aw_hs = aw_valid_i && aw_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;
  assign b_hs  = b_valid_o && b_ready_i;

  assign rd_sel_o = decode(ar_addr_i);
  assign aw_sel   = decode(aw_addr_i);

  // read channel
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      r_state_q <= R_IDLE;
    end else begin
      case (r_state_q)
        R_IDLE: if (ar_hs) r_state_q <= R_DATA;
        R_DATA: if (r_hs) r_state_q <= R_IDLE;
        default: r_state_q <= R_IDLE;
      endcase
    end
  end

  // sample register contents at the ar handshake
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      r_data_q <= rd_data_i;
      r_id_q   <= ar_id_i;
      r_resp_q <= (rd_sel_o == SEL_NONE) ? RESP_SLVERR : RESP_OKAY;
    end
  end

  assign ar_ready_o = (r_state_q == R_IDLE);
  assign r_valid_o  = (r_state_q == R_DATA);
  assign r_last_o   = r_valid_o;
  assign r_data_o   = r_data_q;
  assign r_resp_o   = r_resp_q;
  assign r_id_o     = r_id_q;

  // write channel
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      w_state_q <= W_IDLE;
    end else begin
      case (w_state_q)
        W_IDLE: if (aw_hs) w_state_q <= W_DATA;
        W_DATA: if (w_hs && w_last_i) w_state_q <= W_RESP;
        W_RESP: if (b_hs) w_state_q <= W_IDLE;
        default: w_state_q <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      wr_sel_q <= aw_sel;
      b_id_q   <= aw_id_i;
      b_resp_q <= (aw_sel == SEL_NONE) ? RESP_SLVERR : RESP_OKAY;
    end
  end

  assign aw_ready_o = (w_state_q == W_IDLE);
  assign w_ready_o  = (w_state_q == W_DATA);
  assign b_valid_o  = (w_state_q == W_RESP);
  assign b_resp_o   = b_resp_q;
  assign b_id_o     = b_id_q;

  // every accepted beat writes, unmapped addresses never do
  assign wr_en_o   = w_hs && (wr_sel_q != SEL_NONE);
  assign wr_sel_o  = wr_sel_q;
  assign wr_data_o = w_data_i;
  assign wr_strb_o = w_strb_i;

endmodule

//--- clint_pkg.sv
// CLINT shared definitions
package clint_pkg;

  // bus and register widths
  typedef logic [63:0] clint_word_t;
  typedef logic [31:0] clint_addr_t;
  typedef logic [7:0]  clint_strb_t;
  typedef logic [1:0]  clint_resp_t;

  localparam clint_resp_t RESP_OKAY   = 2'b00;
  localparam clint_resp_t RESP_SLVERR = 2'b10;

  // offsets from the CLINT base address
  localparam clint_addr_t OFF_MSIP     = 32'h0000_0000;
  localparam clint_addr_t OFF_MTIMECMP = 32'h0000_4000;
  localparam clint_addr_t OFF_MTIME    = 32'h0000_bff8;

  localparam clint_word_t MTIMECMP_RESET = 64'h0000_0000_0001_0000;

  typedef enum logic [1:0] {
    SEL_NONE,
    SEL_MSIP,
    SEL_MTIMECMP,
    SEL_MTIME
  } clint_sel_e;

  // merge new data into an old word, byte lanes picked by strb
  function automatic clint_word_t byte_merge(
    input clint_word_t old_word,
    input clint_word_t new_word,
    input clint_strb_t strb
  );
    clint_word_t merged;
    merged = old_word;
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) begin
        merged[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return merged;
  endfunction

endpackage

//--- clint_regs.sv
// CLINT software interrupt and read mux
module clint_regs
  import clint_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        wr_en_i,
  input  clint_sel_e  wr_sel_i,
  input  clint_word_t wr_data_i,
  input  clint_strb_t wr_strb_i,
  input  clint_sel_e  rd_sel_i,
  input  clint_word_t mtime_i,
  input  clint_word_t mtimecmp_i,
  output clint_word_t rd_data_o,
  output logic        soft_irq_o
);

  logic [31:0] msip_q;
  logic        msip_wr;
  clint_word_t msip_merged;
  logic        soft_irq_q;

  assign msip_wr = wr_en_i && (wr_sel_i == SEL_MSIP);

  // byte lane 0 carries the implemented bit
  assign msip_merged = byte_merge({32'b0, msip_q}, wr_data_i, wr_strb_i);

  // only bit 0 is implemented
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      msip_q <= '0;
    end else if (msip_wr) begin
      msip_q <= {31'b0, msip_merged[0]};
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      soft_irq_q <= 1'b0;
    end else begin
      soft_irq_q <= msip_q[0];
    end
  end

  assign soft_irq_o = soft_irq_q;

  // read data is zero when nothing is selected
  always_comb begin
    case (rd_sel_i)
      SEL_MSIP:     rd_data_o = {32'b0, msip_q};
      SEL_MTIMECMP: rd_data_o = mtimecmp_i;
      SEL_MTIME:    rd_data_o = mtime_i;
      default:      rd_data_o = '0;
    endcase
  end

endmodule

//--- clint_tb.sv
// CLINT testbench
module clint_tb
  import clint_pkg::*;
();

  localparam int unsigned ID_WIDTH    = 4;
  localparam clint_addr_t BASE_ADDR   = 32'h0200_0000;
  localparam int          MAX_ENTRIES = 64;

  typedef logic [ID_WIDTH-1:0] id_t;

  typedef enum logic [2:0] {
    OP_WRITE,
    OP_READ,
    OP_READ_TIME,
    OP_SOFT,
    OP_TIMER,
    OP_TIMER_WAIT,
    OP_TIMER_HOLD
  } op_e;

  typedef struct {
    op_e         op;
    clint_addr_t off;
    clint_word_t data;
    clint_strb_t strb;
    clint_word_t exp;
    clint_resp_t resp;
  } entry_t;

  logic        clk, rst;
  logic        aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid, b_ready;
  logic        ar_valid, ar_ready, r_valid, r_ready, r_last;
  logic        soft_irq, timer_irq;
  clint_addr_t aw_addr, ar_addr;
  id_t         aw_id, b_id, ar_id, r_id;
  clint_word_t w_data, r_data;
  clint_strb_t w_strb;
  clint_resp_t b_resp, r_resp;

  entry_t      tbl [MAX_ENTRIES];
  int          n_entries = 0;
  logic        table_ready = 1'b0;
  longint      cycle_cnt = 0;
  logic [31:0] rand_state = 32'h06a7_0592;
  int          err_word = 0;
  int          err_resp = 0;
  int          err_id = 0;
  int          err_bit = 0;
  int          err_other = 0;
  // mtime model, value written and the edge it landed on
  clint_word_t time_base = '0;
  longint      time_wr_cycle = 0;
  clint_word_t prev_time = '0;
  logic        prev_valid = 1'b0;

  clint_top #(
    .ID_WIDTH  (ID_WIDTH),
    .BASE_ADDR (BASE_ADDR),
    .TICK_DIV  (1)
  ) u_dut (
    .clk_i       (clk),
    .rst_i       (rst),
    .aw_valid_i  (aw_valid),
    .aw_ready_o  (aw_ready),
    .aw_addr_i   (aw_addr),
    .aw_id_i     (aw_id),
    .w_valid_i   (w_valid),
    .w_ready_o   (w_ready),
    .w_data_i    (w_data),
    .w_strb_i    (w_strb),
    .w_last_i    (w_last),
    .b_valid_o   (b_valid),
    .b_ready_i   (b_ready),
    .b_resp_o    (b_resp),
    .b_id_o      (b_id),
    .ar_valid_i  (ar_valid),
    .ar_ready_o  (ar_ready),
    .ar_addr_i   (ar_addr),
    .ar_id_i     (ar_id),
    .r_valid_o   (r_valid),
    .r_ready_i   (r_ready),
    .r_data_o    (r_data),
    .r_resp_o    (r_resp),
    .r_last_o    (r_last),
    .r_id_o      (r_id),
    .soft_irq_o  (soft_irq),
    .timer_irq_o (timer_irq)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic pick_delay(output int delay);
    rand_state = xorshift32(rand_state);
    delay = int'(rand_state % 4);
  endtask

  task automatic check_word(input string name, input clint_word_t got, input clint_word_t exp);
    if (got !== exp) begin
      err_word++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input clint_resp_t got, input clint_resp_t exp);
    if (got !== exp) begin
      err_resp++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_id(input string name, input id_t got, input id_t exp);
    if (got !== exp) begin
      err_id++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_bit++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  // read value lies between the written value and that plus the cycles since
  task automatic check_time(input string tag, input clint_word_t got, input longint ar_cycle);
    clint_word_t hi;
    hi = time_base + clint_word_t'(ar_cycle - time_wr_cycle);
    if (got < time_base || got > hi) begin
      err_word++;
      $display("FAIL mtime%s: got %h expected %h to %h", tag, got, time_base, hi);
    end
    if (prev_valid && got <= prev_time) begin
      err_word++;
      $display("FAIL mtime%s: got %h expected above %h", tag, got, prev_time);
    end
    prev_time  = got;
    prev_valid = 1'b1;
  endtask

  task automatic bus_write(input clint_addr_t addr, input clint_word_t data,
                           input clint_strb_t strb, input id_t id, output clint_resp_t resp,
                           output id_t bid, output longint w_cycle);
    logic aw_done;
    logic w_done;
    int   delay;
    aw_done = 1'b0;
    w_done  = 1'b0;
    w_cycle = 0;
    @(posedge clk);
    aw_valid <= 1'b1;
    aw_addr  <= addr;
    aw_id    <= id;
    w_valid  <= 1'b1;
    w_data   <= data;
    w_strb   <= strb;
    w_last   <= 1'b1;
    while (!(aw_done && w_done)) begin
      @(posedge clk);
      if (aw_valid && aw_ready) begin
        aw_done = 1'b1;
        aw_valid <= 1'b0;
      end
      if (w_valid && w_ready) begin
        w_done  = 1'b1;
        w_cycle = cycle_cnt;
        w_valid <= 1'b0;
        w_last  <= 1'b0;
      end
    end
    pick_delay(delay);
    repeat (delay) @(posedge clk);
    b_ready <= 1'b1;
    do begin
      @(posedge clk);
    end while (!(b_valid && b_ready));
    resp = b_resp;
    bid  = b_id;
    b_ready <= 1'b0;
  endtask

  task automatic bus_read(input clint_addr_t addr, input id_t id, output clint_word_t data,
                          output clint_resp_t resp, output id_t rid, output longint ar_cycle);
    int delay;
    @(posedge clk);
    ar_valid <= 1'b1;
    ar_addr  <= addr;
    ar_id    <= id;
    do begin
      @(posedge clk);
    end while (!(ar_valid && ar_ready));
    ar_cycle = cycle_cnt;
    ar_valid <= 1'b0;
    pick_delay(delay);
    repeat (delay) @(posedge clk);
    r_ready <= 1'b1;
    do begin
      @(posedge clk);
    end while (!(r_valid && r_ready));
    data = r_data;
    resp = r_resp;
    rid  = r_id;
    r_ready <= 1'b0;
  endtask

  // irq is registered, so it may rise two edges after mtime reaches the compare value
  task automatic wait_timer(input string tag, input longint min_cycles);
    longint n;
    n = 0;
    do begin
      @(posedge clk);
      n = cycle_cnt - time_wr_cycle;
    end while (timer_irq !== 1'b1 && n <= min_cycles + 3);
    if (timer_irq !== 1'b1) begin
      err_other++;
      $display("timer interrupt%s did not rise within %0d cycles", tag, min_cycles + 3);
    end else if (n < min_cycles) begin
      err_other++;
      $display("timer interrupt%s rose early, %0d cycles after the mtime write", tag, n);
    end
  endtask

  function automatic void add_entry(input op_e op, input clint_addr_t off,
                                    input clint_word_t data, input clint_strb_t strb,
                                    input clint_word_t exp, input clint_resp_t resp);
    tbl[n_entries].op   = op;
    tbl[n_entries].off  = off;
    tbl[n_entries].data = data;
    tbl[n_entries].strb = strb;
    tbl[n_entries].exp  = exp;
    tbl[n_entries].resp = resp;
    n_entries++;
  endfunction

  task automatic fill_table();
    // state after reset
    add_entry(OP_SOFT, '0, 64'h0, 8'h00, '0, RESP_OKAY);
    add_entry(OP_TIMER, '0, 64'h0, 8'h00, '0, RESP_OKAY);
    add_entry(OP_READ, OFF_MTIMECMP, '0, 8'h00, 64'h0000_0000_0001_0000, RESP_OKAY);
    add_entry(OP_READ, OFF_MSIP, '0, 8'h00, 64'h0, RESP_OKAY);
    // software interrupt
    add_entry(OP_WRITE, OFF_MSIP, 64'h1, 8'h01, '0, RESP_OKAY);
    add_entry(OP_SOFT, '0, 64'h1, 8'h00, '0, RESP_OKAY);
    add_entry(OP_READ, OFF_MSIP, '0, 8'h00, 64'h1, RESP_OKAY);
    add_entry(OP_WRITE, OFF_MSIP, 64'h0, 8'h01, '0, RESP_OKAY);
    add_entry(OP_SOFT, '0, 64'h0, 8'h00, '0, RESP_OKAY);
    add_entry(OP_READ, OFF_MSIP, '0, 8'h00, 64'h0, RESP_OKAY);
    add_entry(OP_WRITE, OFF_MSIP, 64'h1, 8'h02, '0, RESP_OKAY);
    add_entry(OP_READ, OFF_MSIP, '0, 8'h00, 64'h0, RESP_OKAY);
    add_entry(OP_WRITE, OFF_MSIP, '1, 8'hff, '0, RESP_OKAY);
    add_entry(OP_READ, OFF_MSIP, '0, 8'h00, 64'h1, RESP_OKAY);
    add_entry(OP_SOFT, '0, 64'h1, 8'h00, '0, RESP_OKAY);
    // byte lanes of mtimecmp
    add_entry(OP_WRITE, OFF_MTIMECMP, 64'h1122_3344_5566_7788, 8'hff, '0, RESP_OKAY);
    add_entry(OP_READ, OFF_MTIMECMP, '0, 8'h00, 64'h1122_3344_5566_7788, RESP_OKAY);
    add_entry(OP_WRITE, OFF_MTIMECMP, 64'haaaa_aaaa_aaaa_aaaa, 8'h0f, '0, RESP_OKAY);
    add_entry(OP_READ, OFF_MTIMECMP, '0, 8'h00, 64'h1122_3344_aaaa_aaaa, RESP_OKAY);
    add_entry(OP_WRITE, OFF_MTIMECMP, 64'h5555_5555_5555_5555, 8'h81, '0, RESP_OKAY);
    add_entry(OP_READ, OFF_MTIMECMP, '0, 8'h00, 64'h5522_3344_aaaa_aa55, RESP_OKAY);
    add_entry(OP_WRITE, OFF_MTIMECMP, '1, 8'h00, '0, RESP_OKAY);
    add_entry(OP_READ, OFF_MTIMECMP, '0, 8'h00, 64'h5522_3344_aaaa_aa55, RESP_OKAY);
    add_entry(OP_WRITE, OFF_MTIMECMP, 64'hcccc_cccc_cccc_cccc, 8'h3c, '0, RESP_OKAY);
    add_entry(OP_READ, OFF_MTIMECMP, '0, 8'h00, 64'h5522_cccc_cccc_aa55, RESP_OKAY);
    // mtime keeps counting
    add_entry(OP_WRITE, OFF_MTIME, 64'h1000, 8'hff, '0, RESP_OKAY);
    add_entry(OP_READ_TIME, OFF_MTIME, '0, 8'h00, '0, RESP_OKAY);
    add_entry(OP_READ_TIME, OFF_MTIME, '0, 8'h00, '0, RESP_OKAY);
    // timer interrupt, compare set 0x30 above the new mtime
    add_entry(OP_WRITE, OFF_MTIME, 64'h2000, 8'hff, '0, RESP_OKAY);
    add_entry(OP_WRITE, OFF_MTIMECMP, 64'h2030, 8'hff, '0, RESP_OKAY);
    add_entry(OP_TIMER, '0, 64'h0, 8'h00, '0, RESP_OKAY);
    add_entry(OP_TIMER_WAIT, '0, 64'h30, 8'h00, '0, RESP_OKAY);
    add_entry(OP_TIMER_HOLD, '0, 64'h8, 8'h00, '0, RESP_OKAY);
    add_entry(OP_WRITE, OFF_MTIMECMP, 64'hffff_ffff_0000_0000, 8'hff, '0, RESP_OKAY);
    add_entry(OP_TIMER, '0, 64'h0, 8'h00, '0, RESP_OKAY);
    // unmapped offsets
    add_entry(OP_READ, 32'h0000_0008, '0, 8'h00, 64'h0, RESP_SLVERR);
    add_entry(OP_READ, 32'h0000_bff0, '0, 8'h00, 64'h0, RESP_SLVERR);
    add_entry(OP_WRITE, 32'h0000_4008, '1, 8'hff, '0, RESP_SLVERR);
    add_entry(OP_WRITE, 32'h0000_0004, 64'h0, 8'hff, '0, RESP_SLVERR);
    add_entry(OP_READ, OFF_MSIP, '0, 8'h00, 64'h1, RESP_OKAY);
    add_entry(OP_READ, OFF_MTIMECMP, '0, 8'h00, 64'hffff_ffff_0000_0000, RESP_OKAY);
    add_entry(OP_READ_TIME, OFF_MTIME, '0, 8'h00, '0, RESP_OKAY);
  endtask

  task automatic run_entry(input int idx);
    entry_t      e;
    id_t         id;
    id_t         got_id;
    clint_word_t got;
    clint_resp_t resp;
    longint      edge_cycle;
    string       tag;
    e   = tbl[idx];
    id  = id_t'(idx);
    tag = $sformatf("[%0d]", idx);
    case (e.op)
      OP_WRITE: begin
        bus_write(BASE_ADDR + e.off, e.data, e.strb, id, resp, got_id, edge_cycle);
        check_resp({"b_resp", tag}, resp, e.resp);
        check_id({"b_id", tag}, got_id, id);
        if (e.off == OFF_MTIME && e.resp == RESP_OKAY) begin
          time_base     = e.data;
          time_wr_cycle = edge_cycle;
          prev_valid    = 1'b0;
        end
      end
      OP_READ, OP_READ_TIME: begin
        bus_read(BASE_ADDR + e.off, id, got, resp, got_id, edge_cycle);
        check_resp({"r_resp", tag}, resp, e.resp);
        check_id({"r_id", tag}, got_id, id);
        if (e.op == OP_READ) begin
          check_word({"r_data", tag}, got, e.exp);
        end else begin
          check_time(tag, got, edge_cycle);
        end
      end
      OP_SOFT: begin
        @(posedge clk);
        check_bit({"soft_irq", tag}, soft_irq, e.data[0]);
      end
      OP_TIMER: begin
        @(posedge clk);
        check_bit({"timer_irq", tag}, timer_irq, e.data[0]);
      end
      OP_TIMER_WAIT: wait_timer(tag, longint'(e.data));
      OP_TIMER_HOLD: begin
        repeat (int'(e.data)) begin
          @(posedge clk);
          check_bit({"timer_irq", tag}, timer_irq, 1'b1);
        end
      end
      default: begin
        err_other++;
        $display("entry %0d has an unknown operation", idx);
      end
    endcase
  endtask

  task automatic report_and_finish();
    int total;
    total = err_word + err_resp + err_id + err_bit + err_other + u_dut.u_assert.fail_cnt;
    $display("errors: data %0d, resp %0d, id %0d, irq %0d, other %0d, assert %0d",
             err_word, err_resp, err_id, err_bit, err_other, u_dut.u_assert.fail_cnt);
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  initial begin : watchdog
    wait (table_ready);
    repeat (n_entries * 40 + 8) @(posedge clk);
    err_other++;
    $display("timeout: run did not finish within %0d cycles", n_entries * 40 + 8);
    report_and_finish();
  end

  initial begin : main
    rst      = 1'b1;
    aw_valid = 1'b0;
    aw_addr  = '0;
    aw_id    = '0;
    w_valid  = 1'b0;
    w_data   = '0;
    w_strb   = '0;
    w_last   = 1'b0;
    b_ready  = 1'b0;
    ar_valid = 1'b0;
    ar_addr  = '0;
    ar_id    = '0;
    r_ready  = 1'b0;
    fill_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < n_entries; i++) begin
      run_entry(i);
    end
    repeat (2) @(posedge clk);
    report_and_finish();
  end

endmodule

//--- clint_tb_assert.sv
// CLINT bus protocol assertions
module clint_tb_assert
  import clint_pkg::*;
(
  input logic        clk_i,
  input logic        rst_i,
  input logic        r_valid_i,
  input logic        r_ready_i,
  input logic        r_last_i,
  input clint_word_t r_data_i,
  input logic        b_valid_i,
  input logic        b_ready_i,
  input clint_resp_t b_resp_i,
  input logic        wr_en_i
);

  int fail_cnt = 0;

  // read response held while the master stalls
  a_r_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_data_i))
  else begin
    fail_cnt++;
    $error("r_valid or r_data changed before r_ready");
  end

  a_b_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_resp_i))
  else begin
    fail_cnt++;
    $error("b_valid or b_resp changed before b_ready");
  end

  // write strobe to the datapath is a single pulse
  a_wr_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    wr_en_i |=> !wr_en_i)
  else begin
    fail_cnt++;
    $error("wr_en held for more than one cycle");
  end

  a_r_last: assert property (@(posedge clk_i) disable iff (rst_i)
    r_last_i == r_valid_i)
  else begin
    fail_cnt++;
    $error("r_last differs from r_valid");
  end

endmodule

// attach to every clint_top instance
bind clint_top clint_tb_assert u_assert (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .r_valid_i (r_valid_o),
  .r_ready_i (r_ready_i),
  .r_last_i  (r_last_o),
  .r_data_i  (r_data_o),
  .b_valid_i (b_valid_o),
  .b_ready_i (b_ready_i),
  .b_resp_i  (b_resp_o),
  .wr_en_i   (wr_en)
);

//--- clint_timer.sv
// CLINT machine timer
module clint_timer
  import clint_pkg::*;
#(
  parameter int unsigned TICK_DIV = 1
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        wr_en_i,
  input  clint_sel_e  wr_sel_i,
  input  clint_word_t wr_data_i,
  input  clint_strb_t wr_strb_i,
  output clint_word_t mtime_o,
  output clint_word_t mtimecmp_o,
  output logic        timer_irq_o
);

  // at least one bit even when every cycle ticks
  localparam int unsigned CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_DIV - 1);

  logic [CNT_W-1:0] div_cnt_q;
  logic             tick;
  logic             mtime_wr;
  logic             mtimecmp_wr;
  clint_word_t      mtime_q;
  clint_word_t      mtimecmp_q;
  logic             timer_irq_q;

  assign tick        = (div_cnt_q == CNT_LAST);
  assign mtime_wr    = wr_en_i && (wr_sel_i == SEL_MTIME);
  assign mtimecmp_wr = wr_en_i && (wr_sel_i == SEL_MTIMECMP);

  // prescaler
  always_ff @(posedge clk_i) begin
    if (rst_i || tick) begin
      div_cnt_q <= '0;
    end else begin
      div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

  // bus write wins over the tick
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtime_q <= '0;
    end else if (mtime_wr) begin
      mtime_q <= byte_merge(mtime_q, wr_data_i, wr_strb_i);
    end else if (tick) begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtimecmp_q <= MTIMECMP_RESET;
    end else if (mtimecmp_wr) begin
      mtimecmp_q <= byte_merge(mtimecmp_q, wr_data_i, wr_strb_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      timer_irq_q <= 1'b0;
    end else begin
      timer_irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  assign mtime_o     = mtime_q;
  assign mtimecmp_o  = mtimecmp_q;
  assign timer_irq_o = timer_irq_q;

endmodule

//--- clint_top.f
clint_pkg.sv
clint_axi_ctrl.sv
clint_timer.sv
clint_regs.sv
clint_top.sv
clint_tb_assert.sv
clint_tb.sv

//--- clint_top.sv
// CLINT top level
module clint_top
  import clint_pkg::*;
#(
  parameter int unsigned ID_WIDTH  = 4,
  parameter clint_addr_t BASE_ADDR = 32'h0200_0000,
  parameter int unsigned TICK_DIV  = 1
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  input  clint_addr_t         aw_addr_i,
  input  logic [ID_WIDTH-1:0] aw_id_i,
  input  logic                w_valid_i,
  output logic                w_ready_o,
  input  clint_word_t         w_data_i,
  input  clint_strb_t         w_strb_i,
  input  logic                w_last_i,
  output logic                b_valid_o,
  input  logic                b_ready_i,
  output clint_resp_t         b_resp_o,
  output logic [ID_WIDTH-1:0] b_id_o,
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  input  clint_addr_t         ar_addr_i,
  input  logic [ID_WIDTH-1:0] ar_id_i,
  output logic                r_valid_o,
  input  logic                r_ready_i,
  output clint_word_t         r_data_o,
  output clint_resp_t         r_resp_o,
  output logic                r_last_o,
  output logic [ID_WIDTH-1:0] r_id_o,
  // interrupts to the hart
  output logic                soft_irq_o,
  output logic                timer_irq_o
);

  logic        wr_en;
  clint_sel_e  wr_sel;
  clint_word_t wr_data;
  clint_strb_t wr_strb;
  clint_sel_e  rd_sel;
  clint_word_t rd_data;
  clint_word_t mtime;
  clint_word_t mtimecmp;

  clint_axi_ctrl #(
    .ID_WIDTH  (ID_WIDTH),
    .BASE_ADDR (BASE_ADDR)
  ) u_ctrl (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .aw_addr_i  (aw_addr_i),
    .aw_id_i    (aw_id_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .w_last_i   (w_last_i),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .b_resp_o   (b_resp_o),
    .b_id_o     (b_id_o),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .ar_addr_i  (ar_addr_i),
    .ar_id_i    (ar_id_i),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .r_data_o   (r_data_o),
    .r_resp_o   (r_resp_o),
    .r_last_o   (r_last_o),
    .r_id_o     (r_id_o),
    .wr_en_o    (wr_en),
    .wr_sel_o   (wr_sel),
    .wr_data_o  (wr_data),
    .wr_strb_o  (wr_strb),
    .rd_sel_o   (rd_sel),
    .rd_data_i  (rd_data)
  );

  clint_timer #(
    .TICK_DIV (TICK_DIV)
  ) u_timer (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wr_en_i     (wr_en),
    .wr_sel_i    (wr_sel),
    .wr_data_i   (wr_data),
    .wr_strb_i   (wr_strb),
    .mtime_o     (mtime),
    .mtimecmp_o  (mtimecmp),
    .timer_irq_o (timer_irq_o)
  );

  clint_regs u_regs (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wr_en_i    (wr_en),
    .wr_sel_i   (wr_sel),
    .wr_data_i  (wr_data),
    .wr_strb_i  (wr_strb),
    .rd_sel_i   (rd_sel),
    .mtime_i    (mtime),
    .mtimecmp_i (mtimecmp),
    .rd_data_o  (rd_data),
    .soft_irq_o (soft_irq_o)
  );

endmodule
